// File: hdl/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

	//////////////////////////////////////////////////
	// Register file map
	//////////////////////////////////////////////////

	// CP0 register numbers, taken from the rd field
	localparam logic [4:0] regSr    = 5'd12;
	localparam logic [4:0] regCause = 5'd13;
	localparam logic [4:0] regEpc   = 5'd14;
	localparam logic [4:0] regPrid  = 5'd15;

	// Processor ID after reset
	localparam logic [31:0] pridValue = 32'h0001_0a31;

	// Status fields
	localparam int srIe   = 0;
	localparam int srExl  = 1;
	localparam int srImLo = 10;
	localparam int srImHi = 15;

	// Cause fields, pending field is six bits wide
	localparam int causeBd   = 31;
	localparam int causeIpLo = 10;

	//////////////////////////////////////////////////
	// Exception codes
	//////////////////////////////////////////////////

	typedef logic [4:0] excCode;

	localparam excCode excNone = 5'd0;
	localparam excCode excAdEL = 5'd4;
	localparam excCode excAdES = 5'd5;
	localparam excCode excRi   = 5'd10;
	localparam excCode excOv   = 5'd12;

	//////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////

	// Primary opcodes the decoder cares about
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opCop0    = 6'h10
	} opcode;

	// Function and rs sub-codes
	localparam logic [5:0] functJr   = 6'h08;
	localparam logic [5:0] functJalr = 6'h09;
	localparam logic [5:0] functEret = 6'h18;
	localparam logic [4:0] rsMf      = 5'h00;
	localparam logic [4:0] rsMt      = 5'h04;

	typedef enum logic [2:0] {
		clsOther = 3'd0,
		clsMfc0  = 3'd1,
		clsMtc0  = 3'd2,
		clsEret  = 3'd3,
		clsJump  = 3'd4
	} instrClass;

	// Memory-stage request into the register block
	typedef struct packed {
		instrClass   cls;
		logic [4:0]  regNum;
		logic [31:0] data;
	} cp0Access;

endpackage

`default_nettype wire

// File: hdl/timerPkg.sv
`default_nettype none

package timerPkg;

	//////////////////////////////////////////////////
	// Timer register map
	//////////////////////////////////////////////////

	localparam logic [3:0] addrCtrl   = 4'd0;
	localparam logic [3:0] addrPreset = 4'd4;

	// Control word layout
	localparam int ctrlEnableBit = 0;
	localparam int ctrlModeBit   = 1;

	//////////////////////////////////////////////////
	// Timer types
	//////////////////////////////////////////////////

	typedef enum logic {
		modeOneShot  = 1'b0,
		modePeriodic = 1'b1
	} timerMode;

	typedef enum logic [1:0] {
		stIdle  = 2'd0,
		stLoad  = 2'd1,
		stCount = 2'd2,
		stIrq   = 2'd3
	} timerState;

	// Single-cycle write, no back-pressure
	typedef struct packed {
		logic        strobe;
		logic [3:0]  addr;
		logic [31:0] data;
	} busWrite;

endpackage

`default_nettype wire

// File: hdl/cp0Decode.sv
`default_nettype none

module cp0Decode (
	input  wire logic [31:0]       instr,
	output cp0Pkg::instrClass      cls
);

	logic [5:0] op;
	logic [4:0] rs;
	logic [5:0] funct;

	// Field split
	assign op    = instr[31:26];
	assign rs    = instr[25:21];
	assign funct = instr[5:0];

	always_comb begin
		cls = cp0Pkg::clsOther;
		case (op)
			cp0Pkg::opCop0: begin
				// CO bit set means a coprocessor operation, not a move
				if (instr[25] && funct == cp0Pkg::functEret) begin
					cls = cp0Pkg::clsEret;
				end else if (rs == cp0Pkg::rsMf) begin
					cls = cp0Pkg::clsMfc0;
				end else if (rs == cp0Pkg::rsMt) begin
					cls = cp0Pkg::clsMtc0;
				end
			end
			cp0Pkg::opSpecial: begin
				// Register jumps
				if (funct == cp0Pkg::functJr || funct == cp0Pkg::functJalr) begin
					cls = cp0Pkg::clsJump;
				end
			end
			// Branches and direct jumps all own a delay slot
			cp0Pkg::opRegimm,
			cp0Pkg::opJ,
			cp0Pkg::opJal,
			cp0Pkg::opBeq,
			cp0Pkg::opBne,
			cp0Pkg::opBlez,
			cp0Pkg::opBgtz: begin
				cls = cp0Pkg::clsJump;
			end
			default: begin
				cls = cp0Pkg::clsOther;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cp0Regs.sv
`default_nettype none

module cp0Regs (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire cp0Pkg::cp0Access  access,
	input  wire cp0Pkg::instrClass wbClass,
	input  wire logic [31:0]       pc,
	input  wire cp0Pkg::excCode    excCode,
	input  wire logic [5:0]        hwInt,
	output logic [31:0]            readData,
	output logic [31:0]            epc,
	output logic                   excTaken
);

	logic [31:0] sr;
	logic [31:0] cause;
	logic [31:0] epcReg;

	logic isMtc0;
	logic isEret;
	logic wbJump;
	logic intReq;
	logic excSet;

	logic [31:0] srWrite;
	logic [31:0] epcEntry;

	//////////////////////////////////////////////////
	// Request logic
	//////////////////////////////////////////////////

	assign isMtc0 = access.cls == cp0Pkg::clsMtc0;
	assign isEret = wbClass == cp0Pkg::clsEret;
	assign wbJump = wbClass == cp0Pkg::clsJump;

	// Masked lines gated by IE and by EXL
	assign intReq = (|(hwInt & sr[cp0Pkg::srImHi:cp0Pkg::srImLo]))
		&& sr[cp0Pkg::srIe] && !sr[cp0Pkg::srExl];
	assign excSet = excCode != cp0Pkg::excNone;

	// Same cycle as the inputs
	assign excTaken = excSet || intReq;

	// Only mask and the two low control bits survive a move to SR
	always_comb begin
		srWrite = '0;
		srWrite[cp0Pkg::srImHi:cp0Pkg::srImLo] =
			access.data[cp0Pkg::srImHi:cp0Pkg::srImLo];
		srWrite[cp0Pkg::srExl] = access.data[cp0Pkg::srExl];
		srWrite[cp0Pkg::srIe]  = access.data[cp0Pkg::srIe];
	end

	// Delay slot points back at the branch
	assign epcEntry = wbJump ? {pc[31:2] - 30'd1, 2'b00} : {pc[31:2], 2'b00};

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////

	// PRId is read-only
	always_comb begin
		case (access.regNum)
			cp0Pkg::regSr:    readData = sr;
			cp0Pkg::regCause: readData = cause;
			cp0Pkg::regEpc:   readData = epcReg;
			cp0Pkg::regPrid:  readData = cp0Pkg::pridValue;
			default:          readData = '0;
		endcase
	end

	assign epc = epcReg;

	//////////////////////////////////////////////////
	// Register updates
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sr     <= '0;
			cause  <= '0;
			epcReg <= '0;
		end else begin
			// Pending lines tracked every cycle
			cause[cp0Pkg::causeIpLo +: 6] <= hwInt;
			if (isMtc0) begin
				// Move wins over exception bookkeeping
				case (access.regNum)
					cp0Pkg::regSr:  sr     <= srWrite;
					cp0Pkg::regEpc: epcReg <= access.data;
					default: begin
					end
				endcase
			end else if (isEret) begin
				sr[cp0Pkg::srExl]      <= 1'b0;
				cause[cp0Pkg::causeBd] <= 1'b0;
			end else if (excTaken) begin
				sr[cp0Pkg::srExl]      <= 1'b1;
				cause[cp0Pkg::causeBd] <= wbJump;
				epcReg                 <= epcEntry;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/timerControl.sv
`default_nettype none

module timerControl (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire timerPkg::busWrite bus,
	input  wire logic             expired,
	output logic                  load,
	output logic                  countEnable,
	output logic                  presetWrite,
	output logic                  irq
);

	timerPkg::timerState state;
	timerPkg::timerState stateNext;
	timerPkg::timerMode  modeReg;
	logic                enableReg;
	logic                ctrlWrite;

	//////////////////////////////////////////////////
	// Bus decode
	//////////////////////////////////////////////////

	assign ctrlWrite   = bus.strobe && bus.addr == timerPkg::addrCtrl;
	assign presetWrite = bus.strobe && bus.addr == timerPkg::addrPreset;

	// Mode and enable, latched on control write
	always_ff @(posedge clk) begin
		if (reset) begin
			modeReg   <= timerPkg::modeOneShot;
			enableReg <= 1'b0;
		end else if (ctrlWrite) begin
			modeReg   <= timerPkg::timerMode'(bus.data[timerPkg::ctrlModeBit]);
			enableReg <= bus.data[timerPkg::ctrlEnableBit];
		end
	end

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		if (ctrlWrite) begin
			// Any control write restarts or stops
			stateNext = bus.data[timerPkg::ctrlEnableBit] ? timerPkg::stLoad : timerPkg::stIdle;
		end else begin
			case (state)
				timerPkg::stIdle:  stateNext = timerPkg::stIdle;
				timerPkg::stLoad:  stateNext = timerPkg::stCount;
				timerPkg::stCount: begin
					if (expired) begin
						stateNext = timerPkg::stIrq;
					end
				end
				timerPkg::stIrq: begin
					// One-shot holds here until software writes control
					if (modeReg == timerPkg::modePeriodic && enableReg) begin
						stateNext = timerPkg::stLoad;
					end
				end
				default: stateNext = timerPkg::stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= timerPkg::stIdle;
		end else begin
			state <= stateNext;
		end
	end

	// Counter steering
	assign load        = state == timerPkg::stLoad;
	assign countEnable = state == timerPkg::stCount;
	assign irq         = state == timerPkg::stIrq;

endmodule

`default_nettype wire

// File: hdl/timerCounter.sv
`default_nettype none

module timerCounter (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        presetWrite,
	input  wire logic [31:0] presetData,
	input  wire logic        load,
	input  wire logic        countEnable,
	output logic             expired
);

	logic [31:0] preset;
	logic [31:0] count;

	//////////////////////////////////////////////////
	// Preset storage
	//////////////////////////////////////////////////

	// Written straight from the bus
	always_ff @(posedge clk) begin
		if (presetWrite) begin
			preset <= presetData;
		end
	end

	//////////////////////////////////////////////////
	// Down-counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			// Load wins over decrement
			count <= preset;
		end else if (countEnable) begin
			count <= count - 32'd1;
		end
	end

	// Last step, so the FSM lands in IRQ with count at zero
	assign expired = countEnable && count == 32'd1;

endmodule

`default_nettype wire

// File: hdl/cp0Subsystem.sv
`default_nettype none

module cp0Subsystem (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic [31:0]       instrMem,
	input  wire logic [31:0]       instrWb,
	input  wire logic [31:0]       writeData,
	input  wire logic [31:0]       pc,
	input  wire cp0Pkg::excCode    excCode,
	input  wire logic [4:0]        hwIntExt,
	input  wire timerPkg::busWrite timerBus,
	output logic [31:0]            readData,
	output logic [31:0]            epc,
	output logic                   excTaken
);

	cp0Pkg::instrClass memClass;
	cp0Pkg::instrClass wbClass;
	cp0Pkg::cp0Access  access;

	logic       timerIrq;
	logic [5:0] hwInt;
	logic       load;
	logic       countEnable;
	logic       presetWrite;
	logic       expired;

	//////////////////////////////////////////////////
	// Decode both stages
	//////////////////////////////////////////////////

	cp0Decode u_decodeMem (
		.instr (instrMem),
		.cls   (memClass)
	);

	cp0Decode u_decodeWb (
		.instr (instrWb),
		.cls   (wbClass)
	);

	// CP0 register number lives in rd
	assign access.cls    = memClass;
	assign access.regNum = instrMem[15:11];
	assign access.data   = writeData;

	// Timer on line 2, lines 7..3 external
	assign hwInt = {hwIntExt, timerIrq};

	cp0Regs u_cp0Regs (
		.clk      (clk),
		.reset    (reset),
		.access   (access),
		.wbClass  (wbClass),
		.pc       (pc),
		.excCode  (excCode),
		.hwInt    (hwInt),
		.readData (readData),
		.epc      (epc),
		.excTaken (excTaken)
	);

	//////////////////////////////////////////////////
	// Interval timer
	//////////////////////////////////////////////////

	timerControl u_timerControl (
		.clk         (clk),
		.reset       (reset),
		.bus         (timerBus),
		.expired     (expired),
		.load        (load),
		.countEnable (countEnable),
		.presetWrite (presetWrite),
		.irq         (timerIrq)
	);

	timerCounter u_timerCounter (
		.clk         (clk),
		.reset       (reset),
		.presetWrite (presetWrite),
		.presetData  (timerBus.data),
		.load        (load),
		.countEnable (countEnable),
		.expired     (expired)
	);

endmodule

`default_nettype wire

// File: test/cp0RefModel.svh
`ifndef cp0RefModelSvh
`define cp0RefModelSvh

//////////////////////////////////////////////////
// Reference state
//////////////////////////////////////////////////

// Bits that survive a move to SR: mask, EXL, IE
localparam logic [31:0] srWritable = 32'h0000_fc03;

logic [31:0]         modelSr;
logic [31:0]         modelCause;
logic [31:0]         modelEpc;
logic [31:0]         modelPreset;
logic [31:0]         modelCount;
logic                modelPeriodic;
logic                modelEnable;
timerPkg::timerState modelState;

// Timer on line 2, external lines above it
function automatic logic [5:0] modelLines();
	modelLines = {hwIntExt, modelState == timerPkg::stIrq};
endfunction

function automatic logic modelExc();
	logic [5:0] lines;
	logic       intReq;
	lines  = modelLines();
	intReq = |(lines & modelSr[cp0Pkg::srImHi:cp0Pkg::srImLo]);
	modelExc = (excCode != 5'd0)
		|| (intReq && modelSr[cp0Pkg::srIe] && !modelSr[cp0Pkg::srExl]);
endfunction

function automatic logic [31:0] modelRead(input logic [4:0] regNum);
	case (regNum)
		5'd12:   modelRead = modelSr;
		5'd13:   modelRead = modelCause;
		5'd14:   modelRead = modelEpc;
		5'd15:   modelRead = cp0Pkg::pridValue;
		default: modelRead = 32'h0;
	endcase
endfunction

task automatic modelReset();
	modelSr       = 32'h0;
	modelCause    = 32'h0;
	modelEpc      = 32'h0;
	modelCount    = 32'h0;
	modelPeriodic = 1'b0;
	modelEnable   = 1'b0;
	modelState    = timerPkg::stIdle;
endtask

// One rising edge, inputs as driven in the cycle before it
task automatic modelStep();
	logic [5:0]          lines;
	logic                exc;
	logic                ctrlHit;
	logic [31:0]         countNext;
	timerPkg::timerState stateNext;
	lines = modelLines();
	exc   = modelExc();
	modelCause[15:10] = lines;
	// Move beats return, return beats exception entry
	if (memCls == cp0Pkg::clsMtc0) begin
		if (memReg == 5'd12) begin
			modelSr = writeData & srWritable;
		end else if (memReg == 5'd14) begin
			modelEpc = writeData;
		end
	end else if (wbCls == cp0Pkg::clsEret) begin
		modelSr[1]     = 1'b0;
		modelCause[31] = 1'b0;
	end else if (exc) begin
		modelSr[1]     = 1'b1;
		modelCause[31] = wbCls == cp0Pkg::clsJump;
		modelEpc = {pc[31:2], 2'b00} - ((wbCls == cp0Pkg::clsJump) ? 32'd4 : 32'd0);
	end
	// Counter follows the state held during this cycle
	countNext = modelCount;
	stateNext = modelState;
	case (modelState)
		timerPkg::stLoad: begin
			countNext = modelPreset;
			stateNext = timerPkg::stCount;
		end
		timerPkg::stCount: begin
			countNext = modelCount - 32'd1;
			if (modelCount == 32'd1) begin
				stateNext = timerPkg::stIrq;
			end
		end
		timerPkg::stIrq: begin
			if (modelPeriodic && modelEnable) begin
				stateNext = timerPkg::stLoad;
			end
		end
		default: begin
		end
	endcase
	ctrlHit = timerBus.strobe && timerBus.addr == 4'd0;
	if (ctrlHit) begin
		stateNext     = timerBus.data[0] ? timerPkg::stLoad : timerPkg::stIdle;
		modelEnable   = timerBus.data[0];
		modelPeriodic = timerBus.data[1];
	end
	if (timerBus.strobe && timerBus.addr == 4'd4) begin
		modelPreset = timerBus.data;
	end
	modelCount = countNext;
	modelState = stateNext;
endtask

`endif

// File: test/cp0SubsystemTb.sv
`default_nettype none

module cp0SubsystemTb;

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////////////////////////
	// Run length and watchdog budget
	//////////////////////////////////////////////////

	localparam int nMoves      = 20;
	localparam int nExc        = 16;
	localparam int nInts       = 24;
	localparam int nOneShot    = 4;
	localparam int nPeriodic   = 3;
	localparam int lenReset    = 6;
	localparam int lenReads    = 32;
	localparam int lenMoves    = 2 * nMoves;
	localparam int lenExc      = 6 * nExc;
	localparam int lenInts     = 3 * nInts;
	localparam int lenOneShot  = 60 * nOneShot;
	localparam int lenPeriodic = 230 * nPeriodic;
	localparam int lenSum      = lenReset + lenReads + lenMoves + lenExc
		+ lenInts + lenOneShot + lenPeriodic;
	localparam int cycleLimit  = (lenSum * 3) / 2;

	// DUT inputs
	logic              clk;
	logic              reset;
	logic [31:0]       instrMem;
	logic [31:0]       instrWb;
	logic [31:0]       writeData;
	logic [31:0]       pc;
	cp0Pkg::excCode    excCode;
	logic [4:0]        hwIntExt;
	timerPkg::busWrite timerBus;

	// DUT outputs
	logic [31:0] readData;
	logic [31:0] epc;
	logic        excTaken;

	// What the stimulus meant, kept beside the encoded words
	cp0Pkg::instrClass memCls;
	cp0Pkg::instrClass wbCls;
	logic [4:0]        memReg;

	logic [31:0] rngState;
	int          stepCount;
	int          watchdogCycles;
	int          checkCount;
	int          errorCount;
	int          testCount;

	`include "cp0RefModel.svh"

	cp0Subsystem u_cp0Subsystem (
		.clk      (clk),
		.reset    (reset),
		.instrMem (instrMem),
		.instrWb  (instrWb),
		.writeData(writeData),
		.pc       (pc),
		.excCode  (excCode),
		.hwIntExt (hwIntExt),
		.timerBus (timerBus),
		.readData (readData),
		.epc      (epc),
		.excTaken (excTaken)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// xorshift32
	function automatic logic [31:0] randomWord();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [31:0] makeInstr(input cp0Pkg::instrClass cls,
		input logic [4:0] regNum, input logic [31:0] fill);
		logic [31:0] word;
		case (cls)
			cp0Pkg::clsMfc0: word = {6'h10, 5'h00, fill[20:16], regNum, 11'h000};
			cp0Pkg::clsMtc0: word = {6'h10, 5'h04, fill[20:16], regNum, 11'h000};
			cp0Pkg::clsEret: word = 32'h4200_0018;
			cp0Pkg::clsJump: begin
				// j, beq, jr or bgtz
				case (fill[27:26])
					2'd0:    word = {6'h02, fill[25:0]};
					2'd1:    word = {6'h04, fill[25:0]};
					2'd2:    word = {6'h00, fill[25:21], 15'h0000, 6'h08};
					default: word = {6'h07, fill[25:21], 5'h00, fill[15:0]};
				endcase
			end
			// addu with random registers
			default: word = {6'h00, fill[25:11], 5'h00, 6'h21};
		endcase
		return word;
	endfunction

	// Edge, model step, then idle inputs 5 ns later
	task automatic nextCycle();
		@(posedge clk);
		if (reset) begin
			modelReset();
		end else begin
			modelStep();
		end
		stepCount++;
		#5;
		instrMem = 32'h0;
		memCls   = cp0Pkg::clsOther;
		memReg   = 5'd0;
		instrWb  = 32'h0;
		wbCls    = cp0Pkg::clsOther;
		excCode  = 5'd0;
		timerBus = '0;
	endtask

	task automatic driveMove(input cp0Pkg::instrClass cls, input logic [4:0] regNum,
		input logic [31:0] data);
		memCls    = cls;
		memReg    = regNum;
		instrMem  = makeInstr(cls, regNum, randomWord());
		writeData = data;
	endtask

	task automatic driveRead(input logic [4:0] regNum);
		driveMove(cp0Pkg::clsMfc0, regNum, randomWord());
	endtask

	task automatic driveWb(input cp0Pkg::instrClass cls);
		wbCls   = cls;
		instrWb = makeInstr(cls, 5'd0, randomWord());
	endtask

	task automatic driveBus(input logic [3:0] addr, input logic [31:0] data);
		timerBus.strobe = 1'b1;
		timerBus.addr   = addr;
		timerBus.data   = data;
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic checkWord(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	// Combinational outputs, 1 ns after the drive
	task automatic checkOutputs();
		#1;
		checkWord("readData", readData, modelRead(memReg));
		checkWord("epc", epc, modelEpc);
		checkFlag("excTaken", excTaken, modelExc());
	endtask

	task automatic checkInterval(input string name, input int stamp, input int origin,
		input int expected);
		if (stamp < 0) begin
			errorCount++;
			$display("%s: the timer interrupt never showed up in Cause", name);
		end else begin
			checkWord(name, 32'(stamp - origin), 32'(expected));
		end
	endtask

	// Polls Cause until bit 10 goes from 0 to 1
	task automatic waitTimerRise(input int limit, output int riseStamp, output int excStamp);
		logic prevBit;
		int   n;
		prevBit   = 1'b1;
		riseStamp = -1;
		excStamp  = -1;
		n         = 0;
		while (riseStamp < 0 && n < limit) begin
			nextCycle();
			driveRead(cp0Pkg::regCause);
			checkOutputs();
			n++;
			if (excTaken && excStamp < 0) begin
				excStamp = stepCount;
			end
			if (readData[cp0Pkg::causeIpLo] && !prevBit) begin
				riseStamp = stepCount;
			end
			prevBit = readData[cp0Pkg::causeIpLo];
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			$display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic testResetReads();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int r = 0; r < 32; r++) begin
			nextCycle();
			driveRead(5'(r));
			checkOutputs();
		end
		finishTest("reset and reads", errorsBefore);
	endtask

	task automatic testMoves();
		int          errorsBefore;
		logic [31:0] r;
		logic [4:0]  target;
		errorsBefore = errorCount;
		for (int i = 0; i < nMoves; i++) begin
			nextCycle();
			r      = randomWord();
			target = r[0] ? cp0Pkg::regEpc : cp0Pkg::regSr;
			driveMove(cp0Pkg::clsMtc0, target, randomWord());
			checkOutputs();
			nextCycle();
			driveRead(target);
			checkOutputs();
		end
		finishTest("moves to CP0", errorsBefore);
	endtask

	task automatic testExceptions();
		int          errorsBefore;
		logic [31:0] r;
		errorsBefore = errorCount;
		for (int i = 0; i < nExc; i++) begin
			nextCycle();
			driveMove(cp0Pkg::clsMtc0, cp0Pkg::regSr, 32'h0);
			checkOutputs();
			nextCycle();
			r       = randomWord();
			excCode = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			pc      = randomWord();
			driveWb(r[8] ? cp0Pkg::clsJump : cp0Pkg::clsOther);
			// Now and then a move in the same cycle holds off the entry
			if (r[10:9] == 2'd0) begin
				driveMove(cp0Pkg::clsMtc0, cp0Pkg::regEpc, randomWord());
			end
			checkOutputs();
			checkFlag("excTaken", excTaken, 1'b1);
			nextCycle();
			driveRead(cp0Pkg::regCause);
			checkOutputs();
			nextCycle();
			driveRead(cp0Pkg::regSr);
			checkOutputs();
			nextCycle();
			driveWb(cp0Pkg::clsEret);
			checkOutputs();
			nextCycle();
			driveRead(cp0Pkg::regCause);
			checkOutputs();
			nextCycle();
			driveRead(cp0Pkg::regSr);
			checkOutputs();
		end
		finishTest("exceptions", errorsBefore);
	endtask

	task automatic testInterrupts();
		int          errorsBefore;
		logic [31:0] r;
		errorsBefore = errorCount;
		for (int i = 0; i < nInts; i++) begin
			nextCycle();
			driveMove(cp0Pkg::clsMtc0, cp0Pkg::regSr, randomWord());
			checkOutputs();
			nextCycle();
			r        = randomWord();
			hwIntExt = r[4:0];
			pc       = randomWord();
			checkOutputs();
			// Pending field shows the lines one edge later
			nextCycle();
			driveRead(cp0Pkg::regCause);
			checkOutputs();
		end
		hwIntExt = 5'd0;
		finishTest("external interrupts", errorsBefore);
	endtask

	task automatic testOneShot();
		int errorsBefore;
		int preset;
		int writeStamp;
		int riseStamp;
		int excStamp;
		errorsBefore = errorCount;
		for (int i = 0; i < nOneShot; i++) begin
			preset = int'(randomWord() % 32'd40) + 1;
			// IE plus mask for line 2 only
			nextCycle();
			driveMove(cp0Pkg::clsMtc0, cp0Pkg::regSr, 32'h0000_0401);
			checkOutputs();
			nextCycle();
			driveBus(timerPkg::addrPreset, 32'(preset));
			checkOutputs();
			nextCycle();
			driveBus(timerPkg::addrCtrl, 32'h1);
			checkOutputs();
			writeStamp = stepCount + 1;
			waitTimerRise(preset + 8, riseStamp, excStamp);
			// timerIrq at P+1, Cause copy one edge after
			checkInterval("excTakenDelay", excStamp, writeStamp, preset + 1);
			checkInterval("causeTimerDelay", riseStamp, writeStamp, preset + 2);
			repeat (4) begin
				nextCycle();
				driveRead(cp0Pkg::regCause);
				checkOutputs();
				checkFlag("causeTimerBit", readData[cp0Pkg::causeIpLo], 1'b1);
			end
			nextCycle();
			driveBus(timerPkg::addrCtrl, 32'h0);
			checkOutputs();
			repeat (2) begin
				nextCycle();
				driveRead(cp0Pkg::regCause);
				checkOutputs();
			end
		end
		finishTest("one-shot timer", errorsBefore);
	endtask

	task automatic testPeriodic();
		int errorsBefore;
		int preset;
		int writeStamp;
		int lastStamp;
		int riseStamp;
		int excStamp;
		int restartDelay;
		errorsBefore = errorCount;
		for (int i = 0; i < nPeriodic; i++) begin
			preset = int'(randomWord() % 32'd40) + 1;
			nextCycle();
			driveMove(cp0Pkg::clsMtc0, cp0Pkg::regSr, 32'h0);
			checkOutputs();
			nextCycle();
			driveBus(timerPkg::addrPreset, 32'(preset));
			checkOutputs();
			nextCycle();
			driveBus(timerPkg::addrCtrl, 32'h3);
			checkOutputs();
			writeStamp = stepCount + 1;
			waitTimerRise(preset + 8, riseStamp, excStamp);
			checkInterval("firstPulseDelay", riseStamp, writeStamp, preset + 2);
			lastStamp = riseStamp;
			// Irq, load, then P count steps
			repeat (2) begin
				waitTimerRise(preset + 8, riseStamp, excStamp);
				checkInterval("timerPeriod", riseStamp, lastStamp, preset + 2);
				lastStamp = riseStamp;
			end
			// Restart while counting
			restartDelay = int'(randomWord() % 32'(preset));
			repeat (restartDelay) begin
				nextCycle();
				driveRead(cp0Pkg::regCause);
				checkOutputs();
			end
			nextCycle();
			driveBus(timerPkg::addrCtrl, 32'h3);
			checkOutputs();
			writeStamp = stepCount + 1;
			waitTimerRise(preset + 8, riseStamp, excStamp);
			checkInterval("restartDelay", riseStamp, writeStamp, preset + 2);
			nextCycle();
			driveBus(timerPkg::addrCtrl, 32'h0);
			checkOutputs();
		end
		finishTest("periodic timer", errorsBefore);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		rngState   = 32'h00ec02fc;
		stepCount  = 0;
		checkCount = 0;
		errorCount = 0;
		testCount  = 0;
		reset      = 1'b1;
		instrMem   = 32'h0;
		instrWb    = 32'h0;
		writeData  = 32'h0;
		pc         = 32'h0000_1000;
		excCode    = 5'd0;
		hwIntExt   = 5'd0;
		timerBus   = '0;
		memCls     = cp0Pkg::clsOther;
		wbCls      = cp0Pkg::clsOther;
		memReg     = 5'd0;
		modelPreset = 32'h0;
		modelReset();
		repeat (5) nextCycle();
		reset = 1'b0;
		testResetReads();
		testMoves();
		testExceptions();
		testInterrupts();
		testOneShot();
		testPeriodic();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		watchdogCycles = 0;
		while (watchdogCycles < cycleLimit) begin
			@(posedge clk);
			watchdogCycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
hdl/cp0Pkg.sv
hdl/timerPkg.sv
hdl/cp0Decode.sv
hdl/cp0Regs.sv
hdl/timerControl.sv
hdl/timerCounter.sv
hdl/cp0Subsystem.sv
test/cp0SubsystemTb.sv
